//--- hw/uio_cmd_pkg.sv
// host protocol definitions shared by the SPI receiver and the command decoder
// command codes, data widths and bit positions in the buttons/switches byte
// modules import it inside their body, ports use scoped names
package uio_cmd_pkg;

	// one byte on the SPI wire
	typedef logic [7:0] spi_byte_t;
	// digital joystick word, filled one byte at a time
	typedef logic [31:0] joy_t;
	typedef logic [31:0] status_t;
	typedef logic [6:0] core_mod_t;
	// byte index inside a frame, saturates at 255
	typedef logic [7:0] frame_cnt_t;

	// command codes sent as the first byte of a frame
	localparam spi_byte_t CMD_BUT_SW   = 8'h01;
	localparam spi_byte_t CMD_KBD      = 8'h05;
	localparam spi_byte_t CMD_STATUS8  = 8'h15;
	localparam spi_byte_t CMD_STATUS32 = 8'h1e;
	localparam spi_byte_t CMD_CORE_MOD = 8'h21;
	localparam spi_byte_t CMD_JOY0     = 8'h60;
	localparam spi_byte_t CMD_JOY1     = 8'h61;
	localparam spi_byte_t CMD_JOY2     = 8'h62;
	localparam spi_byte_t CMD_JOY3     = 8'h63;
	localparam spi_byte_t CMD_JOY4     = 8'h64;

	// ps/2 set 2 prefixes
	localparam spi_byte_t KBD_EXT_PREFIX   = 8'he0;
	localparam spi_byte_t KBD_BREAK_PREFIX = 8'hf0;

	localparam int NUM_JOY = 5;
	// payload bytes that make up one 32-bit word
	localparam frame_cnt_t WORD_BYTES = 8'd4;

	// buttons and switches are 2 bits wide, the rest single flags
	localparam int BIT_BUTTONS  = 0;
	localparam int BIT_SWITCHES = 2;
	localparam int BIT_SCANDBL  = 4;
	localparam int BIT_YPBPR    = 5;
	localparam int BIT_NOCSYNC  = 6;

endpackage

//--- hw/ps2_pkg.sv
// ps/2 keyboard path definitions
// fifo sizing, clock divider ratio and the transmitter states
package ps2_pkg;

	localparam int PS2_FIFO_BITS  = 3;
	localparam int PS2_FIFO_DEPTH = 2 ** PS2_FIFO_BITS;

	// clk_sys cycles per half ps/2 clock, small to keep simulation short
	localparam int PS2_DIV = 4;

	typedef logic [PS2_FIFO_BITS-1:0] ps2_ptr_t;
	// fill level needs one extra bit to tell full from empty
	typedef logic [PS2_FIFO_BITS:0] ps2_fill_t;
	localparam ps2_fill_t PS2_FILL_FULL = ps2_fill_t'(PS2_FIFO_DEPTH);

	// divider counter and its terminal count
	typedef logic [$clog2(PS2_DIV)-1:0] ps2_div_t;
	localparam ps2_div_t PS2_DIV_LAST = ps2_div_t'(PS2_DIV - 1);

	// DATA also covers the start bit, the bit index runs beside it
	typedef enum logic [2:0] {IDLE, DATA, PARITY, STOP, DONE} ps2_tx_state_e;

endpackage

//--- hw/spi_byte_rx.sv
// SPI byte receiver for the host interface
// shifts MOSI in on rising SPI_CLK and hands complete bytes to clk_sys
// through a toggle flag, frame start comes from the synchronized deselect
`timescale 1ns/100ps

module spi_byte_rx (
	input  logic                  clk_sys,
	input  logic                  SPI_SS_IO,
	input  logic                  SPI_CLK,
	input  logic                  SPI_MOSI,
	output logic                  byte_valid,
	output uio_cmd_pkg::spi_byte_t byte_data,
	output logic                  frame_start
);

	import uio_cmd_pkg::*;

	// SPI_CLK domain
	logic [2:0] bit_cnt;
	logic [6:0] sbuf;
	spi_byte_t  rx_byte;
	// flips once per completed byte
	logic       rx_tgl = 1'b0;

	// clk_sys domain
	// toggle synchronizer plus one stage for edge detection
	logic tgl_s1 = 1'b0;
	logic tgl_s2 = 1'b0;
	logic tgl_s3 = 1'b0;
	// deselect level starts high, so no frame start at power-up
	logic ss_s1 = 1'b1;
	logic ss_s2 = 1'b1;
	logic ss_s3 = 1'b1;

	// bit position within the byte
	// restarts at every deselect so each frame is byte aligned
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= 3'd0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	// msb first shift, the eighth bit goes straight into the latch
	always_ff @(posedge SPI_CLK) begin
		sbuf <= {sbuf[5:0], SPI_MOSI};
		if (bit_cnt == 3'd7) begin
			rx_byte <= {sbuf, SPI_MOSI};
			rx_tgl  <= ~rx_tgl;
		end
	end

	// bring toggle and select level into clk_sys
	always_ff @(posedge clk_sys) begin
		tgl_s1 <= rx_tgl;
		tgl_s2 <= tgl_s1;
		tgl_s3 <= tgl_s2;
		ss_s1  <= SPI_SS_IO;
		ss_s2  <= ss_s1;
		ss_s3  <= ss_s2;
	end

	// any toggle edge is one new byte
	assign byte_valid = tgl_s2 ^ tgl_s3;

	// rx_byte is held for a whole byte time, well past the sync delay
	assign byte_data = rx_byte;

	// falling select level starts a frame
	assign frame_start = ss_s3 & ~ss_s2;

endmodule

//--- hw/host_cmd_decoder.sv
// host command decoder in clk_sys
// tracks command and byte index per frame, updates the held core registers
// and turns keyboard bytes into key events and fifo pushes
`timescale 1ns/100ps

module host_cmd_decoder (
	input  logic                  clk_sys,
	input  logic                  SPI_SS_IO,
	input  logic                  byte_valid,
	input  uio_cmd_pkg::spi_byte_t byte_data,
	input  logic                  frame_start,
	output logic [1:0]            buttons,
	output logic [1:0]            switches,
	output logic                  scandoubler_disable,
	output logic                  ypbpr,
	output logic                  no_csync,
	output uio_cmd_pkg::joy_t      joystick_0,
	output uio_cmd_pkg::joy_t      joystick_1,
	output uio_cmd_pkg::joy_t      joystick_2,
	output uio_cmd_pkg::joy_t      joystick_3,
	output uio_cmd_pkg::joy_t      joystick_4,
	output uio_cmd_pkg::status_t   status,
	output uio_cmd_pkg::core_mod_t core_mod,
	output uio_cmd_pkg::spi_byte_t key_code,
	output logic                  key_pressed,
	output logic                  key_extended,
	output logic                  key_strobe,
	output logic                  push,
	output uio_cmd_pkg::spi_byte_t push_data
);

	import uio_cmd_pkg::*;

	// frame tracking
	spi_byte_t  cmd = '0;
	frame_cnt_t byte_idx = '0;

	// held core registers, zero from power-up
	spi_byte_t but_sw = '0;
	joy_t      joy_r [NUM_JOY] = '{default: '0};
	status_t   status_r = '0;
	core_mod_t core_mod_r = '0;

	// prefix state carried between keyboard bytes
	logic key_ext_r = 1'b0;
	logic key_make_r = 1'b1;

	logic       payload_byte;
	logic       in_word;
	logic [1:0] lane;
	logic       kbd_byte;
	logic       kbd_prefix;
	logic       ext_now;
	logic       make_now;

	// byte 0 is the command, later ones are payload
	assign payload_byte = byte_valid && !frame_start && (byte_idx != '0);
	// word payload covers bytes 1 to 4, lsb first
	assign in_word = (byte_idx <= WORD_BYTES);
	assign lane    = byte_idx[1:0] - 2'd1;

	assign kbd_byte   = payload_byte && (cmd == CMD_KBD);
	assign kbd_prefix = (byte_data == KBD_EXT_PREFIX) || (byte_data == KBD_BREAK_PREFIX);
	// first keyboard byte starts a fresh make code
	assign ext_now  = (byte_idx == 8'd1) ? 1'b0 : key_ext_r;
	assign make_now = (byte_idx == 8'd1) ? 1'b1 : key_make_r;

	always_ff @(posedge clk_sys) begin
		if (frame_start) begin
			byte_idx <= '0;
		end else if (byte_valid) begin
			// saturate so long frames never wrap into a command
			if (byte_idx != '1) begin
				byte_idx <= byte_idx + 8'd1;
			end
			if (byte_idx == '0) begin
				cmd <= byte_data;
			end
		end

		if (payload_byte) begin
			case (cmd)
				CMD_BUT_SW: but_sw <= byte_data;
				CMD_JOY0: if (in_word) joy_r[0][{lane, 3'b000} +: 8] <= byte_data;
				CMD_JOY1: if (in_word) joy_r[1][{lane, 3'b000} +: 8] <= byte_data;
				CMD_JOY2: if (in_word) joy_r[2][{lane, 3'b000} +: 8] <= byte_data;
				CMD_JOY3: if (in_word) joy_r[3][{lane, 3'b000} +: 8] <= byte_data;
				CMD_JOY4: if (in_word) joy_r[4][{lane, 3'b000} +: 8] <= byte_data;
				// short status replaces the whole word
				CMD_STATUS8: status_r <= status_t'(byte_data);
				CMD_STATUS32: if (in_word) status_r[{lane, 3'b000} +: 8] <= byte_data;
				CMD_CORE_MOD: core_mod_r <= byte_data[6:0];
				CMD_KBD: begin
					key_ext_r  <= ext_now;
					key_make_r <= make_now;
					if (byte_data == KBD_EXT_PREFIX) begin
						key_ext_r <= 1'b1;
					end else if (byte_data == KBD_BREAK_PREFIX) begin
						key_make_r <= 1'b0;
					end else begin
						// plain code closes the event
						key_code     <= byte_data;
						key_pressed  <= make_now;
						key_extended <= ext_now;
					end
				end
				default: ;
			endcase
		end

		if (kbd_byte) begin
			push_data <= byte_data;
		end
	end

	// strobes
	// raw keyboard bytes go to the fifo, prefixes included
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			key_strobe <= 1'b0;
			push       <= 1'b0;
		end else begin
			push       <= kbd_byte;
			key_strobe <= kbd_byte && !kbd_prefix;
		end
	end

	// buttons/switches byte split into its fields
	assign buttons             = but_sw[BIT_BUTTONS +: 2];
	assign switches            = but_sw[BIT_SWITCHES +: 2];
	assign scandoubler_disable = but_sw[BIT_SCANDBL];
	assign ypbpr               = but_sw[BIT_YPBPR];
	assign no_csync            = but_sw[BIT_NOCSYNC];

	assign joystick_0 = joy_r[0];
	assign joystick_1 = joy_r[1];
	assign joystick_2 = joy_r[2];
	assign joystick_3 = joy_r[3];
	assign joystick_4 = joy_r[4];
	assign status     = status_r;
	assign core_mod   = core_mod_r;

endmodule

//--- hw/ps2_byte_fifo.sv
// keyboard byte queue between the command decoder and the ps/2 transmitter
// eight entries, a push into a full queue is dropped
// head shows the oldest byte whenever empty is low
`timescale 1ns/100ps

module ps2_byte_fifo (
	input  logic                  clk_sys,
	input  logic                  SPI_SS_IO,
	input  logic                  push,
	input  uio_cmd_pkg::spi_byte_t push_data,
	input  logic                  pop,
	output uio_cmd_pkg::spi_byte_t head,
	output logic                  empty
);

	import uio_cmd_pkg::*;
	import ps2_pkg::*;

	spi_byte_t mem [PS2_FIFO_DEPTH];
	// queued bytes survive a deselect, so only power-up clears these
	ps2_ptr_t  wr_ptr = '0;
	ps2_ptr_t  rd_ptr = '0;
	ps2_fill_t fill = '0;

	logic full;
	logic wr_en;
	logic rd_en;

	assign full  = (fill == PS2_FILL_FULL);
	assign empty = (fill == '0);
	// bytes are taken only inside a selected frame
	assign wr_en = push && !full && !SPI_SS_IO;
	assign rd_en = pop && !empty;

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
			wr_ptr      <= wr_ptr + 1'b1;
		end
		if (rd_en) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
		// simultaneous push and pop keeps the level
		case ({wr_en, rd_en})
			2'b10: fill <= fill + 1'b1;
			2'b01: fill <= fill - 1'b1;
			default: ;
		endcase
	end

	assign head = mem[rd_ptr];

endmodule

//--- hw/ps2_kbd_tx.sv
// ps/2 keyboard transmitter
// divides clk_sys into a free running ps/2 clock and sends one fifo byte
// per 11-bit frame: start 0, data lsb first, odd parity, stop 1
// the clock output is held high while nothing is being sent
`timescale 1ns/100ps

module ps2_kbd_tx (
	input  logic                  clk_sys,
	input  logic                  SPI_SS_IO,
	input  uio_cmd_pkg::spi_byte_t head,
	input  logic                  empty,
	output logic                  pop,
	output logic                  ps2_kbd_clk,
	output logic                  ps2_kbd_data
);

	import uio_cmd_pkg::*;
	import ps2_pkg::*;

	// divider, runs from power-up
	ps2_div_t div_cnt = '0;
	logic     ps2_clk = 1'b0;
	logic     clk_rise;

	ps2_tx_state_e state;
	spi_byte_t     tx_byte;
	logic [2:0]    bit_idx;
	logic          parity;

	// high in the cycle where ps2_clk goes from 0 to 1
	assign clk_rise = (div_cnt == PS2_DIV_LAST) && !ps2_clk;

	always_ff @(posedge clk_sys) begin
		if (div_cnt == PS2_DIV_LAST) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// frame sequencing, the line changes on rising ps2 clock
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			state        <= IDLE;
			ps2_kbd_data <= 1'b1;
			pop          <= 1'b0;
		end else begin
			pop <= 1'b0;
			if (clk_rise) begin
				case (state)
					IDLE: if (!empty) begin
						// start bit goes out with the load
						ps2_kbd_data <= 1'b0;
						pop          <= 1'b1;
						state        <= DATA;
					end
					DATA: begin
						ps2_kbd_data <= tx_byte[0];
						if (bit_idx == 3'd7) state <= PARITY;
					end
					PARITY: begin
						ps2_kbd_data <= parity;
						state        <= STOP;
					end
					STOP: begin
						ps2_kbd_data <= 1'b1;
						state        <= DONE;
					end
					// one more clock so the stop bit gets its falling edge
					default: state <= IDLE;
				endcase
			end
		end
	end

	// shift register, bit index and running parity
	always_ff @(posedge clk_sys) begin
		if (clk_rise) begin
			if (state == IDLE) begin
				tx_byte <= head;
				bit_idx <= 3'd0;
				// odd parity starts at 1 and flips on every set bit
				parity  <= 1'b1;
			end else if (state == DATA) begin
				tx_byte <= {1'b0, tx_byte[7:1]};
				bit_idx <= bit_idx + 3'd1;
				parity  <= parity ^ tx_byte[0];
			end
		end
	end

	assign ps2_kbd_clk = ps2_clk | (state == IDLE);

endmodule

//--- hw/user_io_top.sv
// host interface top level
// SPI receiver feeds the command decoder, keyboard bytes queue in the fifo
// and the ps/2 transmitter replays them to the core
`timescale 1ns/100ps

module user_io_top (
	input  logic                  clk_sys,
	input  logic                  SPI_SS_IO,
	input  logic                  SPI_CLK,
	input  logic                  SPI_MOSI,
	output logic [1:0]            buttons,
	output logic [1:0]            switches,
	output logic                  scandoubler_disable,
	output logic                  ypbpr,
	output logic                  no_csync,
	output uio_cmd_pkg::joy_t      joystick_0,
	output uio_cmd_pkg::joy_t      joystick_1,
	output uio_cmd_pkg::joy_t      joystick_2,
	output uio_cmd_pkg::joy_t      joystick_3,
	output uio_cmd_pkg::joy_t      joystick_4,
	output uio_cmd_pkg::status_t   status,
	output uio_cmd_pkg::core_mod_t core_mod,
	output uio_cmd_pkg::spi_byte_t key_code,
	output logic                  key_pressed,
	output logic                  key_extended,
	output logic                  key_strobe,
	output logic                  ps2_kbd_clk,
	output logic                  ps2_kbd_data
);

	import uio_cmd_pkg::*;

	// receiver to decoder
	logic      byte_valid;
	spi_byte_t byte_data;
	logic      frame_start;
	// decoder to fifo
	logic      push;
	spi_byte_t push_data;
	// fifo to transmitter
	spi_byte_t head;
	logic      empty;
	logic      pop;

	spi_byte_rx u_rx (
		.clk_sys, .SPI_SS_IO, .SPI_CLK, .SPI_MOSI,
		.byte_valid, .byte_data, .frame_start
	);

	host_cmd_decoder u_dec (
		.clk_sys, .SPI_SS_IO, .byte_valid, .byte_data, .frame_start,
		.buttons, .switches, .scandoubler_disable, .ypbpr, .no_csync,
		.joystick_0, .joystick_1, .joystick_2, .joystick_3, .joystick_4,
		.status, .core_mod, .key_code, .key_pressed, .key_extended, .key_strobe,
		.push, .push_data
	);

	ps2_byte_fifo u_fifo (
		.clk_sys, .SPI_SS_IO, .push, .push_data, .pop, .head, .empty
	);

	ps2_kbd_tx u_tx (
		.clk_sys, .SPI_SS_IO, .head, .empty, .pop, .ps2_kbd_clk, .ps2_kbd_data
	);

endmodule

//--- verification/user_io_props.sv
// concurrent checks on the keyboard path
// bound once into the command decoder and once into the ps/2 transmitter,
// ports with no counterpart in the bound module are tied to idle levels
`timescale 1ns/100ps

module user_io_props (
	input logic                   clk_sys,
	input logic                   SPI_SS_IO,
	input logic                   key_strobe,
	input logic                   push,
	input logic                   byte_valid,
	input logic                   ps2_kbd_clk,
	input logic                   ps2_kbd_data,
	input ps2_pkg::ps2_tx_state_e state,
	input logic [2:0]             bit_idx
);

	import ps2_pkg::*;

	// count of failed assertions
	int fail_count = 0;

	// key events are single-cycle pulses
	a_key_pulse: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		key_strobe |=> !key_strobe)
		else begin
			$error("key_strobe high for more than one cycle");
			fail_count++;
		end

	// a fifo push always follows a received byte
	a_push_cause: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		push |-> $past(byte_valid))
		else begin
			$error("push without a byte_valid in the cycle before");
			fail_count++;
		end

	// first falling clock of a frame carries the start bit
	a_start_bit: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		($fell(ps2_kbd_clk) && state == DATA && bit_idx == 3'd0) |-> !ps2_kbd_data)
		else begin
			$error("ps2_kbd_data not low at the start bit");
			fail_count++;
		end

	// idle line keeps its clock high, also in the cycle it leaves idle
	// so a frame only starts on a rising ps/2 clock
	a_idle_clk: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		(state == IDLE) |=> ps2_kbd_clk)
		else begin
			$error("ps2_kbd_clk low while or right after the transmitter is idle");
			fail_count++;
		end

endmodule

bind host_cmd_decoder user_io_props u_props_dec (
	.clk_sys(clk_sys), .SPI_SS_IO(SPI_SS_IO),
	.key_strobe(key_strobe), .push(push), .byte_valid(byte_valid),
	.ps2_kbd_clk(1'b1), .ps2_kbd_data(1'b1), .state(ps2_pkg::IDLE), .bit_idx(3'd0)
);

bind ps2_kbd_tx user_io_props u_props_tx (
	.clk_sys(clk_sys), .SPI_SS_IO(SPI_SS_IO),
	.key_strobe(1'b0), .push(1'b0), .byte_valid(1'b0),
	.ps2_kbd_clk(ps2_kbd_clk), .ps2_kbd_data(ps2_kbd_data), .state(state), .bit_idx(bit_idx)
);

//--- verification/user_io_tb.sv
// testbench for the host interface top level
// drives SPI frames from a fixed seed, predicts registers, key events and the
// ps/2 byte stream with its own model, reports per test and then overall
`timescale 1ns/100ps

module user_io_tb;

	import uio_cmd_pkg::*;
	import ps2_pkg::*;

	// clk_sys cycles per half SPI clock
	localparam int SPI_HALF = 4;
	localparam int BYTE_CYCLES = 16 * SPI_HALF;
	// longest frame is the command plus eight keyboard bytes
	localparam int MAX_FRAME_BYTES = 9;
	localparam int NUM_FRAMES = 50;
	localparam int FRAME_CYCLES = MAX_FRAME_BYTES * BYTE_CYCLES + 40;
	// 12 divided rising edges per ps/2 byte plus the wait for the first one
	localparam int PS2_FRAME_CYCLES = 13 * 2 * PS2_DIV;
	localparam int DRAIN_CYCLES = PS2_FIFO_DEPTH * PS2_FRAME_CYCLES;
	localparam int WATCHDOG_CYCLES = 10 + NUM_FRAMES * (FRAME_CYCLES + DRAIN_CYCLES);

	logic clk_sys = 1'b0;
	logic SPI_SS_IO;
	logic SPI_CLK;
	logic SPI_MOSI;

	logic [1:0] buttons, switches;
	logic       scandoubler_disable, ypbpr, no_csync;
	joy_t       joystick_0, joystick_1, joystick_2, joystick_3, joystick_4;
	status_t    status;
	core_mod_t  core_mod;
	spi_byte_t  key_code;
	logic       key_pressed, key_extended, key_strobe;
	logic       ps2_kbd_clk, ps2_kbd_data;

	integer seed = 74;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     test_err0;
	string  test_name;

	// model state, power-up values are all zero
	spi_byte_t   exp_but_sw = '0;
	joy_t        exp_joy [NUM_JOY] = '{default: '0};
	status_t     exp_status = '0;
	core_mod_t   exp_core_mod = '0;
	// key events packed as {extended, pressed, code}
	logic [9:0]  exp_keys [$];
	spi_byte_t   exp_ps2 [$];

	// ps/2 line capture
	logic        ps2_clk_q = 1'b1;
	logic [10:0] ps2_bits = '0;
	int          ps2_nbits = 0;
	logic [9:0]  key_ev;

	user_io_top dut0 (
		.clk_sys, .SPI_SS_IO, .SPI_CLK, .SPI_MOSI,
		.buttons, .switches, .scandoubler_disable, .ypbpr, .no_csync,
		.joystick_0, .joystick_1, .joystick_2, .joystick_3, .joystick_4,
		.status, .core_mod, .key_code, .key_pressed, .key_extended, .key_strobe,
		.ps2_kbd_clk, .ps2_kbd_data
	);

	always #50 clk_sys = ~clk_sys;

	function automatic int rand_range(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic spi_byte_t rand_byte();
		return spi_byte_t'($random(seed));
	endfunction

	// mix of prefixes and plain codes, roughly half prefixes
	function automatic spi_byte_t kbd_byte();
		int pick;
		spi_byte_t code;
		pick = rand_range(4);
		code = rand_byte();
		if (pick == 0) return KBD_EXT_PREFIX;
		if (pick == 1) return KBD_BREAK_PREFIX;
		if (code == KBD_EXT_PREFIX || code == KBD_BREAK_PREFIX) code = code ^ 8'h01;
		return code;
	endfunction

	// own errors plus assertion failures in the bound checkers
	function automatic int total_errors();
		return errors + dut0.u_dec.u_props_dec.fail_count + dut0.u_tx.u_props_tx.fail_count;
	endfunction

	task automatic check_joy(input string name, input joy_t got, input joy_t want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_core_mod(input string name, input core_mod_t got, input core_mod_t want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_pair(input string name, input logic [1:0] got, input logic [1:0] want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_registers();
		check_pair("buttons", buttons, exp_but_sw[BIT_BUTTONS +: 2]);
		check_pair("switches", switches, exp_but_sw[BIT_SWITCHES +: 2]);
		check_bit("scandoubler_disable", scandoubler_disable, exp_but_sw[BIT_SCANDBL]);
		check_bit("ypbpr", ypbpr, exp_but_sw[BIT_YPBPR]);
		check_bit("no_csync", no_csync, exp_but_sw[BIT_NOCSYNC]);
		check_joy("joystick_0", joystick_0, exp_joy[0]);
		check_joy("joystick_1", joystick_1, exp_joy[1]);
		check_joy("joystick_2", joystick_2, exp_joy[2]);
		check_joy("joystick_3", joystick_3, exp_joy[3]);
		check_joy("joystick_4", joystick_4, exp_joy[4]);
		check_status("status", status, exp_status);
		check_core_mod("core_mod", core_mod, exp_core_mod);
	endtask

	// expected effect of one frame, byte 0 is the command
	task automatic apply_model(input spi_byte_t fr[$]);
		spi_byte_t cmd;
		logic ext;
		logic make;
		int i;
		cmd = fr[0];
		ext = 1'b0;
		make = 1'b1;
		for (i = 1; i < fr.size(); i++) begin
			case (cmd)
				CMD_BUT_SW: exp_but_sw = fr[i];
				CMD_STATUS8: exp_status = status_t'(fr[i]);
				CMD_STATUS32: if (i <= WORD_BYTES) exp_status[(i - 1) * 8 +: 8] = fr[i];
				CMD_CORE_MOD: exp_core_mod = fr[i][6:0];
				CMD_JOY0, CMD_JOY1, CMD_JOY2, CMD_JOY3, CMD_JOY4:
					if (i <= WORD_BYTES) exp_joy[cmd - CMD_JOY0][(i - 1) * 8 +: 8] = fr[i];
				CMD_KBD: begin
					// every raw byte goes out on ps/2, prefixes too
					exp_ps2.push_back(fr[i]);
					if (fr[i] == KBD_EXT_PREFIX) ext = 1'b1;
					else if (fr[i] == KBD_BREAK_PREFIX) make = 1'b0;
					else exp_keys.push_back({ext, make, fr[i]});
				end
				default: ;
			endcase
		end
	endtask

	// msb first, SPI_CLK toggles every SPI_HALF cycles
	task automatic send_byte(input spi_byte_t b);
		int i;
		for (i = 7; i >= 0; i--) begin
			SPI_MOSI = b[i];
			repeat (SPI_HALF) @(negedge clk_sys);
			SPI_CLK = 1'b1;
			repeat (SPI_HALF) @(negedge clk_sys);
			SPI_CLK = 1'b0;
		end
	endtask

	task automatic send_frame(input spi_byte_t fr[$]);
		int waited;
		@(negedge clk_sys);
		SPI_SS_IO = 1'b0;
		repeat (6) @(negedge clk_sys);
		foreach (fr[i]) send_byte(fr[i]);
		// let the last byte cross and reach the fifo
		repeat (8) @(negedge clk_sys);
		// deselect resets the transmitter, so hold select until ps/2 is idle
		waited = 0;
		while (exp_ps2.size() != 0 && waited < DRAIN_CYCLES) begin
			@(negedge clk_sys);
			waited++;
		end
		if (exp_ps2.size() != 0) begin
			$display("ps/2 output stalled with %0d bytes still expected", exp_ps2.size());
			errors++;
			exp_ps2.delete();
		end
		SPI_SS_IO = 1'b1;
		repeat (8) @(negedge clk_sys);
	endtask

	task automatic run_frame(input spi_byte_t fr[$]);
		apply_model(fr);
		send_frame(fr);
		check_registers();
		if (exp_keys.size() != 0) begin
			$display("key_strobe missing for %0d expected key events", exp_keys.size());
			errors++;
			exp_keys.delete();
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = total_errors();
	endtask

	task automatic finish_test();
		tests_run++;
		if (total_errors() != test_err0) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, test_name);
		end else begin
			$display("test %0d %s: ok", tests_run, test_name);
		end
	endtask

	task automatic check_ps2_frame(input logic [10:0] f);
		spi_byte_t want;
		if (exp_ps2.size() == 0) begin
			$display("ps/2 frame with data 0x%h arrived with nothing queued", f[8:1]);
			errors++;
		end else begin
			want = exp_ps2.pop_front();
			check_bit("ps2 start bit", f[0], 1'b0);
			check_byte("ps2_kbd_data", f[8:1], want);
			// odd parity over the data byte
			check_bit("ps2 parity bit", f[9], ~^want);
			check_bit("ps2 stop bit", f[10], 1'b1);
		end
	endtask

	// key events, outputs settle half a cycle before the falling edge
	always @(negedge clk_sys) begin
		if (key_strobe === 1'b1) begin
			if (exp_keys.size() == 0) begin
				$display("key_strobe with code 0x%h but no key event expected", key_code);
				errors++;
			end else begin
				key_ev = exp_keys.pop_front();
				check_byte("key_code", key_code, key_ev[7:0]);
				check_bit("key_pressed", key_pressed, key_ev[8]);
				check_bit("key_extended", key_extended, key_ev[9]);
			end
		end
	end

	// ps/2 receiver, one bit per falling ps2_kbd_clk, lsb lands in bit 0
	always @(negedge clk_sys) begin
		if (ps2_clk_q === 1'b1 && ps2_kbd_clk === 1'b0) begin
			ps2_bits = {ps2_kbd_data, ps2_bits[10:1]};
			ps2_nbits++;
			if (ps2_nbits == 11) begin
				ps2_nbits = 0;
				check_ps2_frame(ps2_bits);
			end
		end
		ps2_clk_q = ps2_kbd_clk;
	end

	// watchdog sized from frame count, frame length and ps/2 drain
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout after %0d clk_sys cycles, test sequence stuck", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		spi_byte_t fr[$];
		int k;
		int n;
		SPI_SS_IO = 1'b1;
		SPI_CLK = 1'b0;
		SPI_MOSI = 1'b0;
		repeat (5) @(negedge clk_sys);

		start_test("power-up and buttons/switches");
		check_bit("key_strobe", key_strobe, 1'b0);
		check_bit("ps2_kbd_clk", ps2_kbd_clk, 1'b1);
		check_bit("ps2_kbd_data", ps2_kbd_data, 1'b1);
		check_registers();
		for (k = 0; k < 4; k++) begin
			fr.delete();
			fr.push_back(CMD_BUT_SW);
			fr.push_back(rand_byte());
			run_frame(fr);
		end
		finish_test();

		// 1 to 6 payload bytes, beyond 4 must change nothing
		start_test("joysticks");
		for (k = 0; k < 15; k++) begin
			fr.delete();
			fr.push_back(spi_byte_t'(CMD_JOY0 + rand_range(NUM_JOY)));
			n = 1 + rand_range(6);
			repeat (n) fr.push_back(rand_byte());
			run_frame(fr);
		end
		finish_test();

		start_test("status and core variant");
		for (k = 0; k < 10; k++) begin
			fr.delete();
			case (k % 3)
				0: begin
					fr.push_back(CMD_STATUS32);
					n = 1 + rand_range(6);
					repeat (n) fr.push_back(rand_byte());
				end
				1: begin
					fr.push_back(CMD_STATUS8);
					fr.push_back(rand_byte());
				end
				default: begin
					fr.push_back(CMD_CORE_MOD);
					fr.push_back(rand_byte());
				end
			endcase
			run_frame(fr);
		end
		finish_test();

		start_test("key events");
		for (k = 0; k < 10; k++) begin
			fr.delete();
			fr.push_back(CMD_KBD);
			n = 1 + rand_range(6);
			repeat (n) fr.push_back(kbd_byte());
			run_frame(fr);
		end
		finish_test();

		// long frames keep several bytes queued behind the one on the wire
		start_test("ps/2 byte stream");
		for (k = 0; k < 6; k++) begin
			fr.delete();
			fr.push_back(CMD_KBD);
			repeat (8) fr.push_back(kbd_byte());
			run_frame(fr);
		end
		finish_test();

		// frames cut short, the next first byte is a fresh command
		start_test("aborted frames");
		fr.delete();
		fr.push_back(CMD_JOY2);
		run_frame(fr);
		fr.delete();
		fr.push_back(CMD_STATUS8);
		fr.push_back(rand_byte());
		run_frame(fr);
		fr.delete();
		fr.push_back(CMD_KBD);
		run_frame(fr);
		fr.delete();
		fr.push_back(CMD_BUT_SW);
		fr.push_back(rand_byte());
		run_frame(fr);
		fr.delete();
		fr.push_back(CMD_JOY3);
		fr.push_back(rand_byte());
		fr.push_back(rand_byte());
		run_frame(fr);
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
		if (total_errors() == 0 && tests_failed == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
hw/uio_cmd_pkg.sv
hw/ps2_pkg.sv
hw/spi_byte_rx.sv
hw/host_cmd_decoder.sv
hw/ps2_byte_fifo.sv
hw/ps2_kbd_tx.sv
hw/user_io_top.sv
verification/user_io_props.sv
verification/user_io_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := user_io_tb
FILELIST  := tb.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall
SIMFLAGS  := +verilator+error+limit+1000
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
